// ==== hw/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath word size
`define CORE_DATA_WIDTH 32

// Word address width shared by program and data memory
`define CORE_ADDR_WIDTH 10
`define CORE_MEM_DEPTH 1024

// Register file geometry
`define CORE_REG_ADDR_WIDTH 5
`define CORE_NUM_REGS 32

// Immediate field, sign-extended to a full word
`define CORE_IMM_WIDTH 16

`endif

// ==== hw/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_DATA_WIDTH-1:0]     word_t;
    typedef logic [`CORE_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`CORE_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Instruction field layout, identical for every opcode
    localparam int OPCODE_WIDTH = 6;
    localparam int OPCODE_LSB   = 26;  // Bits 31:26
    localparam int RD_LSB       = 21;  // Bits 25:21
    localparam int RS1_LSB      = 16;  // Bits 20:16
    localparam int RS2_LSB      = 11;  // Bits 15:11
    localparam int IMM_LSB      = 0;   // Bits 15:0
    localparam int FUNCT_LSB    = 0;   // ALU select for OP_ALU
    localparam int FUNCT_WIDTH  = 4;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ALU  = 6'h00,
        OP_ADDI = 6'h01,
        OP_LW   = 6'h02,
        OP_SW   = 6'h03,
        OP_BEQ  = 6'h04,
        OP_HALT = 6'h3f
    } opcode_e;

    typedef enum logic [FUNCT_WIDTH-1:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLT = 4'h5,
        ALU_SLL = 4'h6,
        ALU_SRL = 4'h7
    } alu_op_e;

    localparam word_t NOP_INSTR = '0;  // add r0, r0, r0

    function automatic word_t sign_ext_imm(input logic [`CORE_IMM_WIDTH-1:0] imm);
        return {{(`CORE_DATA_WIDTH - `CORE_IMM_WIDTH){imm[`CORE_IMM_WIDTH-1]}}, imm};
    endfunction

endpackage

// ==== hw/core_ctrl_if.sv ====
`timescale 1ns/1ns

interface core_ctrl_if;
    import core_pkg::*;

    alu_op_e alu_op;
    logic    use_imm;    // Second operand is the immediate
    word_t   imm_val;
    logic    mem_write;
    logic    mem_read;
    logic    reg_write;
    logic    is_branch;
    logic    is_halt;

    modport decoder (
        output alu_op, use_imm, imm_val, mem_write, mem_read,
               reg_write, is_branch, is_halt
    );

    modport datapath (
        input alu_op, use_imm, imm_val, mem_write, mem_read, is_branch
    );

    modport sequencer (
        input is_branch, is_halt, imm_val
    );

endinterface

// ==== hw/core_prog_mem.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_prog_mem (
    input  logic            clk,
    input  logic            load_we,
    input  core_pkg::addr_t load_addr,
    input  core_pkg::word_t load_data,
    input  core_pkg::addr_t addr,
    output core_pkg::word_t instr
);
    import core_pkg::*;

    // Contents survive reset so a preloaded program can run afterwards
    word_t mem [`CORE_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    assign instr = mem[addr];  // Fetch is combinational

    // An undefined load address would corrupt an unknown word
    a_load_addr_known: assert property (
        @(posedge clk) load_we |-> !$isunknown(load_addr)
    ) else $error("program load with unknown address");

endmodule

// ==== hw/core_data_mem.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_data_mem (
    input  logic            clk,
    input  logic            rst_n,
    core_ctrl_if.datapath   ctrl,
    input  core_pkg::addr_t addr,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rdata
);
    import core_pkg::*;

    word_t mem [`CORE_MEM_DEPTH];

    // Cleared in reset so every program starts from zeroed data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.mem_write) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

    // The decoder never asks for a load and a store in one instruction
    a_no_read_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write)
    ) else $error("data memory read and write in the same cycle");

endmodule

// ==== hw/core_control_unit.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_control_unit (
    input  core_pkg::word_t     instr,
    core_ctrl_if.decoder        ctrl,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    output core_pkg::reg_addr_t rd_addr
);
    import core_pkg::*;

    opcode_e                    opcode;
    logic [`CORE_IMM_WIDTH-1:0] imm;

    // Register addresses sit at fixed field positions in every instruction
    assign opcode   = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
    assign rd_addr  = instr[RD_LSB +: `CORE_REG_ADDR_WIDTH];
    assign rs1_addr = instr[RS1_LSB +: `CORE_REG_ADDR_WIDTH];
    assign rs2_addr = instr[RS2_LSB +: `CORE_REG_ADDR_WIDTH];
    assign imm      = instr[IMM_LSB +: `CORE_IMM_WIDTH];

    always_comb begin
        ctrl.alu_op    = ALU_ADD;  // Address and immediate adds
        ctrl.use_imm   = 1'b0;
        ctrl.imm_val   = sign_ext_imm(imm);
        ctrl.mem_write = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.is_branch = 1'b0;
        ctrl.is_halt   = 1'b0;

        case (opcode)
            OP_ALU: begin
                ctrl.alu_op    = alu_op_e'(instr[FUNCT_LSB +: FUNCT_WIDTH]);
                ctrl.reg_write = 1'b1;
            end
            OP_ADDI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;  // Store data comes from rs2
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                ctrl.is_branch = 1'b1;
            end
            OP_HALT: begin
                ctrl.is_halt   = 1'b1;
            end
            default: begin
                ctrl.is_halt   = 1'b1;  // Unknown opcode stops the core
            end
        endcase
    end

endmodule

// ==== hw/core_program_counter.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_program_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    core_ctrl_if.sequencer  ctrl,
    input  logic            take_branch,
    output core_pkg::addr_t pc,
    output logic            halted
);
    import core_pkg::*;

    addr_t pc_plus1;
    addr_t pc_next;

    assign pc_plus1 = pc + addr_t'(1);

    // Offset counts words from PC plus one and wraps at the memory depth
    assign pc_next = (ctrl.is_branch && take_branch)
                   ? pc_plus1 + ctrl.imm_val[`CORE_ADDR_WIDTH-1:0]
                   : pc_plus1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (run && !halted) begin
            if (ctrl.is_halt) begin
                halted <= 1'b1;  // PC stays on the halt instruction
            end else begin
                pc <= pc_next;
            end
        end
    end

    a_pc_frozen: assert property (
        @(posedge clk) (halted && rst_n) |=> $stable(pc)
    ) else $error("PC moved while halted");

endmodule

// ==== hw/core_regfile.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rs1,
    output core_pkg::word_t     rs2
);
    import core_pkg::*;

    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= wdata;  // r0 is never written
        end
    end

    // Register zero reads as zero
    assign rs1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/core_execution_unit.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core_execution_unit (
    core_ctrl_if.datapath   ctrl,
    input  core_pkg::word_t rs1,
    input  core_pkg::word_t rs2,
    input  core_pkg::word_t mem_rdata,
    output core_pkg::word_t alu_result,
    output core_pkg::word_t wb_data,
    output logic            take_branch
);
    import core_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`CORE_DATA_WIDTH);

    word_t                  op_b;
    logic [SHAMT_WIDTH-1:0] shamt;

    assign op_b  = ctrl.use_imm ? ctrl.imm_val : rs2;  // Operand mux
    assign shamt = op_b[SHAMT_WIDTH-1:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_result = rs1 + op_b;
            ALU_SUB: alu_result = rs1 - op_b;
            ALU_AND: alu_result = rs1 & op_b;
            ALU_OR:  alu_result = rs1 | op_b;
            ALU_XOR: alu_result = rs1 ^ op_b;
            ALU_SLT: alu_result = word_t'($signed(rs1) < $signed(op_b));
            ALU_SLL: alu_result = rs1 << shamt;
            ALU_SRL: alu_result = rs1 >> shamt;
            default: alu_result = '0;  // Undefined function code
        endcase
    end

    // Compares the registers directly, not through the immediate mux
    assign take_branch = ctrl.is_branch && (rs1 == rs2);

    assign wb_data = ctrl.mem_read ? mem_rdata : alu_result;

endmodule

// ==== hw/core.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module core (
    input  logic                clk,
    input  logic                rst_n,
    // Program load
    input  logic                load_we,
    input  core_pkg::addr_t     load_addr,
    input  core_pkg::word_t     load_data,
    input  logic                run,
    // Retire
    output logic                retire_reg_we,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_data,
    output logic                store_we,
    output core_pkg::addr_t     store_addr,
    output core_pkg::word_t     store_data,
    output logic                halted
);
    import core_pkg::*;

    core_ctrl_if ctrl ();

    addr_t     pc;
    addr_t     mem_addr;
    word_t     instr;
    word_t     dec_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1;
    word_t     rs2;
    word_t     alu_result;
    word_t     wb_data;
    word_t     mem_rdata;
    logic      take_branch;
    logic      core_active;
    logic      reg_we;

    assign core_active = run && !halted;

    // Stalled or halted cycles decode a bubble, so no store can commit
    assign dec_instr = core_active ? instr : NOP_INSTR;

    assign reg_we   = core_active && ctrl.reg_write;
    assign mem_addr = alu_result[`CORE_ADDR_WIDTH-1:0];  // Word address

    core_prog_mem u_prog_mem (
        .clk       (clk),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .addr      (pc),
        .instr     (instr)
    );

    core_control_unit u_control_unit (
        .instr    (dec_instr),
        .ctrl     (ctrl.decoder),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr)
    );

    core_program_counter u_program_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .ctrl        (ctrl.sequencer),
        .take_branch (take_branch),
        .pc          (pc),
        .halted      (halted)
    );

    core_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (reg_we),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .wdata    (wb_data),
        .rs1      (rs1),
        .rs2      (rs2)
    );

    core_execution_unit u_execution_unit (
        .ctrl        (ctrl.datapath),
        .rs1         (rs1),
        .rs2         (rs2),
        .mem_rdata   (mem_rdata),
        .alu_result  (alu_result),
        .wb_data     (wb_data),
        .take_branch (take_branch)
    );

    core_data_mem u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl.datapath),
        .addr  (mem_addr),
        .wdata (rs2),
        .rdata (mem_rdata)
    );

    // Commit view of the current instruction
    assign retire_reg_we = reg_we && (rd_addr != '0);  // r0 writes are hidden
    assign retire_rd     = rd_addr;
    assign retire_data   = wb_data;
    assign store_we      = core_active && ctrl.mem_write;
    assign store_addr    = mem_addr;
    assign store_data    = rs2;

endmodule

// ==== tests/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
    import core_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 4;  // Quiet cycles watched after halt
    localparam int SETUP_SLACK  = 8;

    logic      clk;
    logic      rst_n;
    logic      load_we;
    addr_t     load_addr;
    word_t     load_data;
    logic      run;
    logic      retire_reg_we;
    reg_addr_t retire_rd;
    word_t     retire_data;
    logic      store_we;
    addr_t     store_addr;
    word_t     store_data;
    logic      halted;

    logic [8*16-1:0] test_name[$];
    int              test_budget[$];
    int              prog_end[$];  // One past the last word of each record
    int              event_end[$];
    addr_t           prog_addr[$];
    word_t           prog_word[$];
    logic            event_is_store[$];
    word_t           event_loc[$];  // Register number or store address
    word_t           event_val[$];
    int              errors;
    int              bad_lines;

    core DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic string kind_name(input logic is_store);
        return is_store ? "store" : "reg";
    endfunction

    task automatic read_patterns();
        int               fd;
        logic [7:0]       tag;
        logic [8*16-1:0]  name;
        logic [8*128-1:0] rest;
        int               budget;
        word_t            a;
        word_t            v;
        fd = $fopen("tests/core_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/core_patterns.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "T": begin
                    if ($fscanf(fd, "%s %d", name, budget) != 2) bad_lines++;
                    test_name.push_back(name);
                    test_budget.push_back(budget);
                end
                "P": begin
                    if ($fscanf(fd, "%h %h", a, v) != 2) bad_lines++;
                    prog_addr.push_back(addr_t'(a));
                    prog_word.push_back(v);
                end
                "R", "S": begin
                    if ($fscanf(fd, "%h %h", a, v) != 2) bad_lines++;
                    event_is_store.push_back(tag == "S");
                    event_loc.push_back(a);
                    event_val.push_back(v);
                end
                "E": begin
                    prog_end.push_back(prog_addr.size());
                    event_end.push_back(event_is_store.size());
                end
                default: void'($fgets(rest, fd));  // Comment runs to end of line
            endcase
        end
        $fclose(fd);
        if (bad_lines != 0) begin
            $display("%0d malformed lines in the patterns file", bad_lines);
            errors++;
        end
    endtask

    task automatic check_event(input int t, input logic is_store, input word_t loc,
                               input word_t val, inout int next_ev);
        if (next_ev >= event_end[t]) begin
            $display("%0s: unexpected %0s event at %0h with value %h",
                     test_name[t], kind_name(is_store), loc, val);
            errors++;
        end else begin
            if (is_store != event_is_store[next_ev] || loc != event_loc[next_ev] ||
                val != event_val[next_ev]) begin
                $display("[FAIL] %0s: expected %0s %0h = %h, actual %0s %0h = %h",
                         test_name[t], kind_name(event_is_store[next_ev]),
                         event_loc[next_ev], event_val[next_ev],
                         kind_name(is_store), loc, val);
                errors++;
            end
            next_ev++;
        end
    endtask

    task automatic run_test(input int t);
        logic [8*16-1:0] name;
        int              next_ev;
        int              cycles;
        name    = test_name[t];
        next_ev = (t == 0) ? 0 : event_end[t-1];
        cycles  = 0;
        @(negedge clk);
        run   = 1'b0;
        rst_n = 1'b0;
        for (int p = (t == 0) ? 0 : prog_end[t-1]; p < prog_end[t]; p++) begin
            load_we   = 1'b1;
            load_addr = prog_addr[p];
            load_data = prog_word[p];
            @(negedge clk);
        end
        load_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (halted) begin
            $display("%0s: halted is still set after reset", name);
            errors++;
        end
        while (!halted) begin
            if (cycles == test_budget[t]) begin
                $display("%0s: no halt within the budget of %0d cycles", name, cycles);
                errors++;
                break;
            end
            run = !(cycles >= 2 && cycles < 5);  // Short stall early in each run
            @(posedge clk);
            if (!run && (retire_reg_we || store_we)) begin
                $display("%0s: commit seen while run is low", name);
                errors++;
            end else if (retire_reg_we) begin
                check_event(t, 1'b0, word_t'(retire_rd), retire_data, next_ev);
            end else if (store_we) begin
                check_event(t, 1'b1, word_t'(store_addr), store_data, next_ev);
            end
            cycles++;
            @(negedge clk);
        end
        if (halted) begin
            if (next_ev < event_end[t]) begin
                $display("%0s: halted with %0d expected events missing",
                         name, event_end[t] - next_ev);
                errors++;
            end
            repeat (DRAIN_CYCLES) begin
                @(posedge clk);
                if (retire_reg_we || store_we || !halted) begin
                    $display("%0s: commit or halt change after halt", name);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int limit;
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run       = 1'b0;
        errors    = 0;
        bad_lines = 0;
        read_patterns();
        if (prog_end.size() == 0) begin
            $display("No complete test records were read");
            errors++;
        end
        limit = prog_word.size();
        foreach (prog_end[t]) begin
            limit += test_budget[t] + RESET_CYCLES + DRAIN_CYCLES + SETUP_SLACK;
        end
        fork
            begin
                #(limit * CLK_PERIOD);
                $display("Watchdog expired after %0d cycles", limit);
                $display("Simulation FAILED");
                $finish;
            end
        join_none
        foreach (prog_end[t]) begin
            run_test(t);
        end
        $display("Tests: %0d, errors: %0d", prog_end.size(), errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/core_patterns.txt ====
# Records  T name budget, P word_addr instr, R rd value, S word_addr value, E closes
# Hex values except the decimal budget in cycles; events are expected in listed order
T alu_ops 24
P 000 0400004D                  # addi r0, r0, 77 shows no event
P 001 0420000C  R 01 0000000C   # addi r1, r0, 12
P 002 0440FFFB  R 02 FFFFFFFB   # addi r2, r0, -5
P 003 04600003  R 03 00000003   # addi r3, r0, 3
P 004 00811000  R 04 00000007   # add  r4, r1, r2
P 005 00A11001  R 05 00000011   # sub  r5, r1, r2
P 006 00C11002  R 06 00000008   # and  r6, r1, r2
P 007 00E11003  R 07 FFFFFFFF   # or   r7, r1, r2
P 008 01011004  R 08 FFFFFFF7   # xor  r8, r1, r2
P 009 01220805  R 09 00000001   # slt  r9, r2, r1
P 00A 01411005  R 0A 00000000   # slt  r10, r1, r2
P 00B 01611806  R 0B 00000060   # sll  r11, r1, r3
P 00C 01821807  R 0C 1FFFFFFF   # srl  r12, r2, r3
P 00D 01A01800  R 0D 00000003   # add  r13, r0, r3
P 00E FC000000                  # halt
E
# Store and branch immediates share bits 15:11 with rs2, only bits 9:0 reach the address
T mem_access 18
P 000 04201234  R 01 00001234   # addi r1, r0, 0x1234
P 001 04400008  R 02 00000008   # addi r2, r0, 8
P 002 0C020804  S 00C 00001234  # sw   r1, 4(r2)
P 003 0460FFFF  R 03 FFFFFFFF   # addi r3, r0, -1
P 004 0C001820  S 020 FFFFFFFF  # sw   r3, 0x20(r0)
P 005 08820004  R 04 00001234   # lw   r4, 4(r2)
P 006 08A00020  R 05 FFFFFFFF   # lw   r5, 0x20(r0)
P 007 08C00030  R 06 00000000   # lw   r6, 0x30(r0) never written
P 008 FC000000                  # halt
E
T reload_clear 12
P 000 0820000C  R 01 00000000   # lw   r1, 0xC(r0) cleared by reset
P 001 00440000  R 02 00000000   # add  r2, r4, r0
P 002 08600020  R 03 00000000   # lw   r3, 0x20(r0)
P 003 A8200005                  # opcode 0x2A halts
P 004 04200002                  # addi r1, r0, 2 never runs
E
T branch_loop 30
P 000 04200003  R 01 00000003   # addi r1, r0, 3
P 001 04400000  R 02 00000000   # addi r2, r0, 0
P 002 10011001                  # beq  r1, r2, +1 not taken
P 003 04600007  R 03 00000007   # addi r3, r0, 7
P 004 10000001                  # beq  r0, r0, +1 taken
P 005 04800063                  # addi r4, r0, 99 skipped
P 006 04420002                  # loop head, addi r2, r2, 2
P 007 0421FFFF                  # addi r1, r1, -1
P 008 10010001                  # beq  r1, r0, +1 leaves the loop
P 009 100003FC                  # beq  r0, r0, -4
P 00A 00A20000                  # add  r5, r2, r0
P 00B FC000000                  # halt
R 02 00000002  R 01 00000002
R 02 00000004  R 01 00000001
R 02 00000006  R 01 00000000
R 05 00000006
E

// ==== tb.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_ctrl_if.sv
hw/core_prog_mem.sv
hw/core_data_mem.sv
hw/core_control_unit.sv
hw/core_program_counter.sv
hw/core_regfile.sv
hw/core_execution_unit.sv
hw/core.sv
tests/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_core -f tb.f \
    && ./obj_dir/Vtb_core | tee /dev/stderr | grep -q '^Simulation PASSED$' \
    || { echo "Verilator run did not pass"; exit 1; }

echo "Verilator run passed"
exit 0
